// File: common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int WordWidth = 16;
    localparam int AddrWidth = 16;

    typedef logic [WordWidth-1:0] wordT;
    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [7:0]           byteT;     // Address byte and immediates
    typedef logic [1:0]           regIdxT;

    typedef enum logic [5:0] {
        OpBra  = 6'h00,
        OpBne  = 6'h01,
        OpBeq  = 6'h02,
        OpInc  = 6'h05,
        OpDec  = 6'h06,
        OpAnd  = 6'h0C,
        OpOr   = 6'h0D,
        OpNot  = 6'h0E,
        OpXor  = 6'h0F,
        OpMovh = 6'h11,
        OpLdr  = 6'h12,
        OpStr  = 6'h13,
        OpMovl = 6'h14,
        OpAdd  = 6'h15,
        OpSub  = 6'h17,
        OpLdi  = 6'h20
    } opcodeT;

    typedef enum logic [3:0] {
        AluPassA, AluPassB, AluNot, AluAdd, AluSub, AluAnd, AluOr, AluXor
    } aluFunT;

    typedef enum logic [2:0] {
        BankHold, BankLoad, BankInc, BankDec, BankClear, BankLoadLow, BankLoadHigh
    } bankFunT;

    // Write source shared by both register banks
    typedef enum logic [1:0] {
        WrSrcAlu, WrSrcMem, WrSrcImm, WrSrcBranch
    } wrSrcT;

    // Instruction field positions
    localparam int OpcodeLsb = 10;
    localparam int SBit      = 9;
    localparam int RegLsb    = 8;    // Rx of MOVH, MOVL, LDR, STR, LDI
    localparam int DstLsb    = 6;
    localparam int Src1Lsb   = 3;
    localparam int Src2Lsb   = 0;

    // Address bank entries, SP slot left idle
    localparam regIdxT PcIdx = 2'd0;
    localparam regIdxT ArIdx = 2'd1;

endpackage

`default_nettype wire

// File: controlUnit/instructionDecoder.sv
`default_nettype none

module instructionDecoder (
    input  cpuPkg::wordT   instr,
    output cpuPkg::opcodeT opcode,
    output logic           sFlag,
    output cpuPkg::regIdxT dstIdx,
    output cpuPkg::regIdxT src1Idx,
    output cpuPkg::regIdxT src2Idx,
    output logic           dstInGen,
    output logic           srcInGen,
    output cpuPkg::byteT   immByte,
    output logic           isAluOne,
    output logic           isAluTwo,
    output logic           isMem,
    output logic           isBranch,
    output cpuPkg::aluFunT aluFun
);
    import cpuPkg::*;

    assign opcode  = opcodeT'(instr[OpcodeLsb +: 6]);
    assign sFlag   = instr[SBit];
    assign src1Idx = instr[Src1Lsb +: 2];
    assign src2Idx = instr[Src2Lsb +: 2];
    assign immByte = instr[7:0];

    always_comb
    begin
        isAluOne = 1'b0;
        isAluTwo = 1'b0;
        aluFun   = AluPassA;     // INC and DEC copy the source first
        case (opcode)
            OpInc, OpDec: isAluOne = 1'b1;
            OpNot:
            begin
                isAluOne = 1'b1;
                aluFun   = AluNot;
            end
            OpAnd:
            begin
                isAluTwo = 1'b1;
                aluFun   = AluAnd;
            end
            OpOr:
            begin
                isAluTwo = 1'b1;
                aluFun   = AluOr;
            end
            OpXor:
            begin
                isAluTwo = 1'b1;
                aluFun   = AluXor;
            end
            OpAdd:
            begin
                isAluTwo = 1'b1;
                aluFun   = AluAdd;
            end
            OpSub:
            begin
                isAluTwo = 1'b1;
                aluFun   = AluSub;
            end
            default: ;
        endcase
    end

    assign isMem    = opcode inside {OpLdr, OpStr, OpLdi};
    assign isBranch = opcode inside {OpBra, OpBne, OpBeq};

    // Bit 2 of a register field picks the general file
    assign dstInGen = instr[DstLsb + 2];
    assign srcInGen = instr[Src1Lsb + 2] && (!isAluTwo || instr[Src2Lsb + 2]);

    // ALU ops name a 3-bit destination, the rest a 2-bit Rx
    assign dstIdx = (isAluOne || isAluTwo) ? instr[DstLsb +: 2] : instr[RegLsb +: 2];

endmodule

`default_nettype wire

// File: controlUnit/controlSequencer.sv
`default_nettype none

module controlSequencer (
    input  logic            Clock,
    input  logic            rstN,
    input  cpuPkg::wordT    instr,
    input  logic            zFlag,
    input  logic            memAck,
    output logic            memReq,
    output logic            memWrite,
    output logic            irLoad,
    output cpuPkg::bankFunT genFun,
    output cpuPkg::regIdxT  genSel,
    output cpuPkg::bankFunT adrFun,
    output cpuPkg::regIdxT  adrSel,
    output cpuPkg::aluFunT  aluFun,
    output logic            flagWrite,
    output cpuPkg::regIdxT  srcA,
    output cpuPkg::regIdxT  srcB,
    output cpuPkg::regIdxT  memAddrSel,
    output cpuPkg::wrSrcT   wrSel,
    output cpuPkg::byteT    immByte
);
    import cpuPkg::*;

    localparam logic [3:0] T0 = 4'b0001;
    localparam logic [3:0] T1 = 4'b0010;
    localparam logic [3:0] T2 = 4'b0100;
    localparam logic [3:0] T3 = 4'b1000;

    opcodeT     opcode;
    aluFunT     decAluFun;
    regIdxT     dstIdx;
    regIdxT     src1Idx;
    regIdxT     src2Idx;
    logic       sFlag;
    logic       dstInGen;
    logic       srcInGen;
    logic       isAluOne;
    logic       isAluTwo;
    logic       isMem;
    logic       isBranch;
    logic [3:0] tState;
    logic [3:0] tNext;
    logic       aluOk;
    logic       isIncDec;
    logic       isLdi;
    logic       isStr;
    logic       taken;
    logic       memStep;
    logic       ackDone;
    logic       finishMem;

    instructionDecoder decoder (
        .instr    (instr),
        .opcode   (opcode),
        .sFlag    (sFlag),
        .dstIdx   (dstIdx),
        .src1Idx  (src1Idx),
        .src2Idx  (src2Idx),
        .dstInGen (dstInGen),
        .srcInGen (srcInGen),
        .immByte  (immByte),
        .isAluOne (isAluOne),
        .isAluTwo (isAluTwo),
        .isMem    (isMem),
        .isBranch (isBranch),
        .aluFun   (decAluFun)
    );

    assign aluOk    = (isAluOne || isAluTwo) && dstInGen && srcInGen;  // Else a no-op
    assign isIncDec = aluOk && (opcode == OpInc || opcode == OpDec);
    assign isLdi    = opcode == OpLdi;
    assign isStr    = opcode == OpStr;
    assign taken    = (opcode == OpBra) || (opcode == OpBne && !zFlag)
                   || (opcode == OpBeq && zFlag);

    // States that wait on the memory handshake
    assign memStep   = tState[0] || (tState[2] && isMem && !isLdi) || (tState[3] && isLdi);
    assign ackDone   = memReq && memAck;
    assign finishMem = ackDone && memStep && !tState[0];

    assign genSel     = dstIdx;
    assign srcA       = src1Idx;
    assign srcB       = isStr ? dstIdx : src2Idx;    // STR sends Rx on port B
    assign memAddrSel = tState[0] ? PcIdx : ArIdx;

    always_comb
    begin
        tNext = T0;
        case (1'b1)
            tState[0]: tNext = T1;
            tState[1]: tNext = T2;
            tState[2]: tNext = (isLdi || isIncDec) ? T3 : T0;
            default:   tNext = T0;
        endcase
    end

    always_comb
    begin
        irLoad    = 1'b0;
        genFun    = BankHold;
        adrFun    = BankHold;
        adrSel    = PcIdx;
        aluFun    = AluPassA;
        flagWrite = 1'b0;
        wrSel     = WrSrcAlu;
        case (1'b1)
            tState[0]:
            begin
                if (ackDone)
                begin
                    irLoad = 1'b1;
                    adrFun = BankInc;        // PC past the fetched word
                end
            end
            tState[2]:
            begin
                if (aluOk)
                begin
                    genFun    = BankLoad;
                    aluFun    = decAluFun;
                    flagWrite = isAluTwo && sFlag;
                end
                else if (opcode == OpMovh || opcode == OpMovl)
                begin
                    genFun = (opcode == OpMovh) ? BankLoadHigh : BankLoadLow;
                    wrSel  = WrSrcImm;
                end
                else if (isBranch)
                begin
                    adrFun = taken ? BankLoad : BankHold;
                    wrSel  = WrSrcBranch;
                end
                else if (isLdi)
                begin
                    adrFun = BankLoad;       // AR from the address byte
                    adrSel = ArIdx;
                    wrSel  = WrSrcImm;
                end
            end
            tState[3]:
            begin
                if (isIncDec)
                    genFun = (opcode == OpInc) ? BankInc : BankDec;
            end
            default: ;
        endcase

        // Ack of LDR, STR or LDI read, AR post-increment
        if (finishMem)
        begin
            genFun = isStr ? BankHold : BankLoad;
            wrSel  = WrSrcMem;
            adrFun = BankInc;
            adrSel = ArIdx;
        end
    end

    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
        begin
            tState   <= T0;
            memReq   <= 1'b0;
            memWrite <= 1'b0;
        end
        else
        begin
            if (memStep && !memReq && !memAck)
            begin
                memReq   <= 1'b1;
                memWrite <= tState[2] && isStr;
            end
            else if (ackDone)
            begin
                memReq   <= 1'b0;
                memWrite <= 1'b0;
            end
            if (!memStep || ackDone)
                tState <= tNext;     // Hold while the access is pending
        end
    end

endmodule

`default_nettype wire

// File: datapath/registerBank.sv
`default_nettype none

module registerBank #(
    parameter type     payloadT   = cpuPkg::wordT,
    parameter payloadT ResetValue = '0
) (
    input  logic            Clock,
    input  logic            rstN,
    input  cpuPkg::bankFunT fun,
    input  cpuPkg::regIdxT  sel,
    input  payloadT         writeData,
    input  cpuPkg::regIdxT  readIdxA,
    input  cpuPkg::regIdxT  readIdxB,
    output payloadT         readA,
    output payloadT         readB
);
    import cpuPkg::*;

    localparam int Width     = $bits(payloadT);
    localparam int HalfWidth = Width / 2;

    payloadT regs [4];

    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 4; i++)
                regs[i] <= ResetValue;
        end
        else
        begin
            case (fun)
                BankLoad:     regs[sel] <= writeData;
                BankInc:      regs[sel] <= regs[sel] + payloadT'(1);
                BankDec:      regs[sel] <= regs[sel] - payloadT'(1);
                BankClear:    regs[sel] <= '0;
                BankLoadLow:  regs[sel][HalfWidth-1:0] <= writeData[HalfWidth-1:0];
                BankLoadHigh: regs[sel][Width-1:HalfWidth] <= writeData[Width-1:HalfWidth];
                default: ;   // Hold
            endcase
        end
    end

    assign readA = regs[readIdxA];
    assign readB = regs[readIdxB];

endmodule

`default_nettype wire

// File: datapath/alu.sv
`default_nettype none

module alu (
    input  logic           Clock,
    input  logic           rstN,
    input  cpuPkg::aluFunT fun,
    input  cpuPkg::wordT   a,
    input  cpuPkg::wordT   b,
    input  logic           flagWrite,
    output cpuPkg::wordT   result,
    output logic           zFlag
);
    import cpuPkg::*;

    localparam int Msb = WordWidth - 1;

    logic       carry;
    logic       overflow;
    logic [3:0] flags;     // Z, C, N, O

    always_comb
    begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (fun)
            AluPassB: result = b;
            AluNot:   result = ~a;
            AluAnd:   result = a & b;
            AluOr:    result = a | b;
            AluXor:   result = a ^ b;
            AluAdd:
            begin
                {carry, result} = {1'b0, a} + {1'b0, b};
                overflow = (a[Msb] == b[Msb]) && (result[Msb] != a[Msb]);
            end
            AluSub:
            begin
                // Carry set means no borrow
                {carry, result} = {1'b0, a} + {1'b0, ~b} + 17'd1;
                overflow = (a[Msb] != b[Msb]) && (result[Msb] != a[Msb]);
            end
            default:  result = a;
        endcase
    end

    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
            flags <= 4'b0000;
        else if (flagWrite)
            flags <= {result == '0, carry, result[Msb], overflow};
    end

    assign zFlag = flags[3];

endmodule

`default_nettype wire

// File: datapath/datapath.sv
`default_nettype none

module datapath #(
    parameter cpuPkg::addrT ResetPc = '0
) (
    input  logic            Clock,
    input  logic            rstN,
    input  logic            irLoad,
    input  cpuPkg::bankFunT genFun,
    input  cpuPkg::regIdxT  genSel,
    input  cpuPkg::bankFunT adrFun,
    input  cpuPkg::regIdxT  adrSel,
    input  cpuPkg::aluFunT  aluFun,
    input  logic            flagWrite,
    input  cpuPkg::regIdxT  srcA,
    input  cpuPkg::regIdxT  srcB,
    input  cpuPkg::regIdxT  memAddrSel,
    input  cpuPkg::wrSrcT   wrSel,
    input  cpuPkg::byteT    immByte,
    input  cpuPkg::wordT    memRdData,
    output cpuPkg::wordT    instr,
    output logic            zFlag,
    output cpuPkg::addrT    memAddr,
    output cpuPkg::wordT    memWrData
);
    import cpuPkg::*;

    wordT genA;
    wordT genB;
    wordT aluResult;
    wordT genWrData;
    addrT adrWrData;
    addrT pcValue;
    addrT branchTarget;

    // Instruction register
    always_ff @(posedge Clock or negedge rstN)
    begin
        if (!rstN)
            instr <= '0;
        else if (irLoad)
            instr <= memRdData;
    end

    // PC already points past the branch here
    assign branchTarget = pcValue + {{(AddrWidth - 8){immByte[7]}}, immByte};

    always_comb
    begin
        case (wrSel)
            WrSrcMem: genWrData = memRdData;
            WrSrcImm: genWrData = {immByte, immByte};   // Either half for MOVH/MOVL
            default:  genWrData = aluResult;
        endcase
    end

    assign adrWrData = (wrSel == WrSrcImm) ? addrT'(immByte) : branchTarget;

    registerBank #(
        .payloadT (wordT)
    ) genBank (
        .Clock     (Clock),
        .rstN      (rstN),
        .fun       (genFun),
        .sel       (genSel),
        .writeData (genWrData),
        .readIdxA  (srcA),
        .readIdxB  (srcB),
        .readA     (genA),
        .readB     (genB)
    );

    registerBank #(
        .payloadT   (addrT),
        .ResetValue (ResetPc)
    ) adrBank (
        .Clock     (Clock),
        .rstN      (rstN),
        .fun       (adrFun),
        .sel       (adrSel),
        .writeData (adrWrData),
        .readIdxA  (memAddrSel),
        .readIdxB  (PcIdx),
        .readA     (memAddr),
        .readB     (pcValue)
    );

    alu alu (
        .Clock     (Clock),
        .rstN      (rstN),
        .fun       (aluFun),
        .a         (genA),
        .b         (genB),
        .flagWrite (flagWrite),
        .result    (aluResult),
        .zFlag     (zFlag)
    );

    assign memWrData = genB;     // STR reads Rx on port B

endmodule

`default_nettype wire

// File: verilog/cpuTop.sv
`default_nettype none

module cpuTop #(
    parameter cpuPkg::addrT ResetPc = 16'h0000
) (
    input  logic         Clock,
    input  logic         rstN,
    input  logic         memAck,
    input  cpuPkg::wordT memRdData,
    output logic         memReq,
    output logic         memWrite,
    output cpuPkg::addrT memAddr,
    output cpuPkg::wordT memWrData
);
    import cpuPkg::*;

    wordT    instr;
    logic    zFlag;
    logic    irLoad;
    logic    flagWrite;
    bankFunT genFun;
    bankFunT adrFun;
    regIdxT  genSel;
    regIdxT  adrSel;
    regIdxT  srcA;
    regIdxT  srcB;
    regIdxT  memAddrSel;
    aluFunT  aluFun;
    wrSrcT   wrSel;
    byteT    immByte;

    controlSequencer sequencer (
        .Clock      (Clock),
        .rstN       (rstN),
        .instr      (instr),
        .zFlag      (zFlag),
        .memAck     (memAck),
        .memReq     (memReq),
        .memWrite   (memWrite),
        .irLoad     (irLoad),
        .genFun     (genFun),
        .genSel     (genSel),
        .adrFun     (adrFun),
        .adrSel     (adrSel),
        .aluFun     (aluFun),
        .flagWrite  (flagWrite),
        .srcA       (srcA),
        .srcB       (srcB),
        .memAddrSel (memAddrSel),
        .wrSel      (wrSel),
        .immByte    (immByte)
    );

    datapath #(
        .ResetPc (ResetPc)
    ) datapath (
        .Clock      (Clock),
        .rstN       (rstN),
        .irLoad     (irLoad),
        .genFun     (genFun),
        .genSel     (genSel),
        .adrFun     (adrFun),
        .adrSel     (adrSel),
        .aluFun     (aluFun),
        .flagWrite  (flagWrite),
        .srcA       (srcA),
        .srcB       (srcB),
        .memAddrSel (memAddrSel),
        .wrSel      (wrSel),
        .immByte    (immByte),
        .memRdData  (memRdData),
        .instr      (instr),
        .zFlag      (zFlag),
        .memAddr    (memAddr),
        .memWrData  (memWrData)
    );

endmodule

`default_nettype wire

// File: tb/cpuTop_chk.sv
`default_nettype none

module cpuTop_chk (
    input wire logic         Clock,
    input wire logic         rstN,
    input wire logic         memAck,
    input wire logic         memReq,
    input wire logic         memWrite,
    input wire cpuPkg::addrT memAddr,
    input wire cpuPkg::wordT memWrData
);
    timeunit 1ns;
    timeprecision 100ps;

    // No request while reset holds
    reqLowInReset: assert property (@(posedge Clock) !rstN |-> !memReq)
        else $error("memReq high during reset");

    // Request held until acknowledged
    reqHeldForAck: assert property (
        @(posedge Clock) disable iff (!rstN)
        memReq && !memAck |=> memReq
    ) else $error("memReq dropped before memAck");

    // Address, direction and data fixed for the whole request
    reqStable: assert property (
        @(posedge Clock) disable iff (!rstN)
        memReq && !memAck |=> $stable(memAddr) && $stable(memWrite) && $stable(memWrData)
    ) else $error("Request fields changed while memReq was high");

    // Next request waits for memAck to fall
    noReqDuringAck: assert property (
        @(posedge Clock) disable iff (!rstN)
        !memReq && memAck |=> !memReq
    ) else $error("memReq rose while memAck was high");

endmodule

`default_nettype wire

// File: tb/cpuTb.sv
`default_nettype none

module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuPkg::*;

    localparam int   NumStores = 13;
    localparam addrT StoreBase = 16'h0082;
    localparam wordT OpA       = 16'h3C5A;
    localparam wordT OpB       = 16'h1234;
    localparam wordT Data0     = 16'hA5C3;   // Read back by LDI
    localparam wordT Data1     = 16'h0F0F;   // Read back by LDR

    logic Clock = 1'b0;
    logic rstN  = 1'b0;
    logic memAck = 1'b0;
    wordT memRdData = '0;
    logic memReq;
    logic memWrite;
    addrT memAddr;
    wordT memWrData;

    wordT        mem [256];
    wordT        expData [NumStores];
    int          storeCount = 0;
    logic        pending = 1'b0;
    logic [1:0]  waitCnt = '0;
    logic [15:0] lfsr = 16'd96;

    cpuTop #(
        .ResetPc (16'h0000)
    ) UUT (
        .Clock     (Clock),
        .rstN      (rstN),
        .memAck    (memAck),
        .memRdData (memRdData),
        .memReq    (memReq),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .memWrData (memWrData)
    );

    bind cpuTop cpuTop_chk chk (.*);

    initial
    begin
        forever #2 Clock = ~Clock;
    end

    function automatic logic [15:0] lfsrStep(logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // ALU format with general-file bit set in every field
    function automatic wordT aluInstr(opcodeT op, logic s, regIdxT d, regIdxT a, regIdxT b);
        return {op, s, 1'b1, d, 1'b1, a, 1'b1, b};
    endfunction

    function automatic wordT rxInstr(opcodeT op, regIdxT rx, byteT imm);
        return {op, rx, imm};
    endfunction

    // Program words plus the two data words; 28 and 31 lie behind taken branches
    function automatic logic readAllowed(addrT a);
        if (a == 16'h0080 || a == 16'h0081)
            return 1'b1;
        return a <= 16'd33 && a != 16'd28 && a != 16'd31;
    endfunction

    task automatic stopRun(string what);
        $display("%s at %0t ns", what, $time);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(string name, wordT got, wordT exp);
        assert (got === exp)
        else
        begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            stopRun("Value mismatch");
        end
    endtask

    // Memory side of the four-phase handshake
    always @(posedge Clock)
    begin : responder
        logic [15:0] s1;
        if (!rstN)
        begin
            memAck  <= 1'b0;
            pending <= 1'b0;
        end
        else if (memReq && !memAck)
        begin
            if (!pending)
            begin
                s1 = lfsrStep(lfsr);
                waitCnt <= {lfsr[0], s1[0]};
                lfsr    <= lfsrStep(s1);
                pending <= 1'b1;
            end
            else if (waitCnt != 0)
                waitCnt <= waitCnt - 2'd1;
            else
            begin
                pending <= 1'b0;
                memAck  <= 1'b1;
                if (memAddr > 16'h00FF)
                    stopRun("Access outside the memory image");
                if (memWrite)
                begin
                    if (storeCount >= NumStores)
                        stopRun("Store beyond the expected list");
                    checkValue("memAddr", memAddr, StoreBase + addrT'(storeCount));
                    checkValue("memWrData", memWrData, expData[storeCount]);
                    mem[memAddr[7:0]] <= memWrData;
                    storeCount <= storeCount + 1;
                end
                else
                begin
                    if (!readAllowed(memAddr))
                        stopRun("Read from an address the branch rule skips");
                    memRdData <= mem[memAddr[7:0]];
                end
            end
        end
        else if (!memReq && memAck)
            memAck <= 1'b0;
    end

    initial
    begin
        int cycles;
        for (int i = 0; i < 256; i++)
            mem[i] = wordT'(i * 16'h9E37) ^ 16'h5A5A;    // Fill pattern
        mem[0]  = rxInstr(OpMovh, 2'd0, OpA[15:8]);
        mem[1]  = rxInstr(OpMovl, 2'd0, OpA[7:0]);
        mem[2]  = rxInstr(OpMovl, 2'd1, OpB[7:0]);     // Low half first, MOVH must keep it
        mem[3]  = rxInstr(OpMovh, 2'd1, OpB[15:8]);
        mem[4]  = rxInstr(OpLdi, 2'd3, 8'h80);
        mem[5]  = rxInstr(OpLdr, 2'd2, 8'h00);
        mem[6]  = rxInstr(OpStr, 2'd0, 8'h00);
        mem[7]  = rxInstr(OpStr, 2'd3, 8'h00);
        mem[8]  = rxInstr(OpStr, 2'd2, 8'h00);
        mem[9]  = aluInstr(OpAdd, 1'b0, 2'd2, 2'd0, 2'd1);
        mem[11] = aluInstr(OpSub, 1'b0, 2'd2, 2'd0, 2'd1);
        mem[13] = aluInstr(OpAnd, 1'b0, 2'd2, 2'd0, 2'd1);
        mem[15] = aluInstr(OpOr, 1'b0, 2'd2, 2'd0, 2'd1);
        mem[17] = aluInstr(OpXor, 1'b0, 2'd2, 2'd0, 2'd1);
        mem[19] = aluInstr(OpNot, 1'b0, 2'd2, 2'd0, 2'd0);
        mem[21] = aluInstr(OpInc, 1'b0, 2'd2, 2'd0, 2'd0);
        mem[23] = aluInstr(OpDec, 1'b0, 2'd2, 2'd1, 2'd0);
        for (int i = 10; i <= 24; i += 2)
            mem[i] = rxInstr(OpStr, 2'd2, 8'h00);
        mem[25] = aluInstr(OpSub, 1'b1, 2'd3, 2'd0, 2'd0);     // Zero result sets Z
        mem[26] = rxInstr(OpBne, 2'd0, 8'h01);
        mem[27] = rxInstr(OpBeq, 2'd0, 8'h01);
        mem[28] = rxInstr(OpStr, 2'd0, 8'h00);
        mem[29] = rxInstr(OpStr, 2'd3, 8'h00);
        mem[30] = rxInstr(OpBra, 2'd0, 8'h01);
        mem[31] = rxInstr(OpStr, 2'd0, 8'h00);
        mem[32] = rxInstr(OpStr, 2'd1, 8'h00);
        mem[33] = rxInstr(OpBra, 2'd0, 8'hFF);                 // Spin in place
        mem[128] = Data0;
        mem[129] = Data1;

        expData[0]  = OpA;
        expData[1]  = Data0;
        expData[2]  = Data1;
        expData[3]  = OpA + OpB;
        expData[4]  = OpA - OpB;
        expData[5]  = OpA & OpB;
        expData[6]  = OpA | OpB;
        expData[7]  = OpA ^ OpB;
        expData[8]  = ~OpA;
        expData[9]  = OpA + 16'd1;
        expData[10] = OpB - 16'd1;
        expData[11] = 16'h0000;
        expData[12] = OpB;

        repeat (10) @(posedge Clock);
        rstN <= 1'b1;

        cycles = 0;
        while (storeCount < NumStores && cycles < 4000)
        begin
            @(posedge Clock);
            cycles++;
        end
        if (storeCount < NumStores)
            stopRun("Timeout waiting for the expected stores");

        // Let the spin loop run to catch a late extra store
        cycles = 0;
        while (cycles < 80)
        begin
            @(posedge Clock);
            cycles++;
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
common/cpuPkg.sv
controlUnit/instructionDecoder.sv
controlUnit/controlSequencer.sv
datapath/registerBank.sv
datapath/alu.sv
datapath/datapath.sv
verilog/cpuTop.sv
tb/cpuTop_chk.sv
tb/cpuTb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the cpuTb simulation"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --top-module cpuTb -f verilog.f -o simv
	@out=$$(./obj_dir/simv 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
